//--- mulacc_top.f
+incdir+include
hw/mulacc_pkg.sv
hw/mulacc_apb_regs.sv
hw/bw_pp_gen.sv
hw/bw_reduce.sv
hw/mac_accumulate.sv
hw/mulacc_top.sv
bench/mulacc_tb.sv

//--- Bender.yml
package:
  name: mulacc

sources:
  - files:
      - hw/mulacc_pkg.sv
      - hw/mulacc_apb_regs.sv
      - hw/bw_pp_gen.sv
      - hw/bw_reduce.sv
      - hw/mac_accumulate.sv
      - hw/mulacc_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/mulacc_tb.sv

//--- include/mulacc_ref.svh
`ifndef MULACC_REF_SVH
`define MULACC_REF_SVH

// Exact signed product, modulo 2**32.
function automatic logic [mulacc_pkg::PROD_W-1:0] ref_mul_exact(
    input logic [mulacc_pkg::MUL_W-1:0] x,
    input logic [mulacc_pkg::MUL_W-1:0] y
);
    logic signed [mulacc_pkg::PROD_W-1:0] p;
    p = $signed(x) * $signed(y);
    return p;
endfunction

// Approximate product, rows 0 to 5 replaced by the correction table.
function automatic logic [mulacc_pkg::PROD_W-1:0] ref_mul_approx(
    input logic [mulacc_pkg::MUL_W-1:0] x,
    input logic [mulacc_pkg::MUL_W-1:0] y
);
    logic [mulacc_pkg::PP_W-1:0]   r [mulacc_pkg::MUL_W];
    logic [mulacc_pkg::CORR_W-1:0] c [mulacc_pkg::CORR_WORDS];
    logic [mulacc_pkg::PROD_W-1:0] sum;
    for (int i = 0; i < mulacc_pkg::MUL_W; i++) begin
        r[i] = y & {mulacc_pkg::PP_W{x[i]}};
        if (i == mulacc_pkg::MUL_W - 1) begin
            r[i][mulacc_pkg::PP_W-2:0] = ~r[i][mulacc_pkg::PP_W-2:0];
        end else begin
            r[i][mulacc_pkg::PP_W-1] = ~r[i][mulacc_pkg::PP_W-1];
        end
    end
    c = '{default: '0};
    c[0][3]  = r[0][2] & r[1][1];
    c[0][4]  = r[0][4] ^ r[1][3];
    c[0][5]  = r[4][1] ^ r[5][0];
    c[0][6]  = r[0][5] & r[1][4];
    c[0][7]  = r[2][5] ^ r[3][4];
    c[0][9]  = r[4][5] ^ r[5][4];
    c[0][13] = r[2][10] & r[3][9];
    c[0][14] = r[4][10] ^ r[5][9];
    c[0][15] = r[2][13] ^ r[3][12];
    c[0][16] = 1'b1;
    c[0][17] = r[1][15];
    c[0][18] = r[2][15] & r[3][14];
    c[0][19] = r[4][14] & r[5][13];
    c[0][20] = r[4][15] & r[5][14];
    c[1][3]  = r[0][3] ^ r[1][2];
    c[1][4]  = r[2][2] ^ r[3][1];
    c[1][7]  = r[4][2] & r[5][1];
    c[1][16] = r[4][12] ^ r[5][11];
    c[1][17] = r[2][15] ^ r[3][14];
    c[1][18] = r[3][15];
    c[1][19] = r[4][15] ^ r[5][14];
    c[1][20] = r[5][15];
    c[2][17] = r[4][12] & r[5][11];
    c[2][18] = r[4][14] ^ r[5][13];
    c[3][17] = r[4][13] ^ r[5][12];
    sum = mulacc_pkg::PROD_W'(1) << (mulacc_pkg::PROD_W - 1);
    for (int w = 0; w < mulacc_pkg::CORR_WORDS; w++) begin
        sum = sum + mulacc_pkg::PROD_W'(c[w]);
    end
    for (int i = mulacc_pkg::APPROX_ROWS; i < mulacc_pkg::MUL_W; i++) begin
        sum = sum + (mulacc_pkg::PROD_W'(r[i]) << i);
    end
    return sum;
endfunction

// Fibonacci LFSR, taps 32 22 2 1.
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], fb};
endfunction

// One operand, one LFSR step per bit.
function automatic logic [mulacc_pkg::MUL_W-1:0] lfsr_operand(inout logic [31:0] state);
    logic [mulacc_pkg::MUL_W-1:0] v;
    for (int i = 0; i < mulacc_pkg::MUL_W; i++) begin
        state = lfsr_step(state);
        v[i]  = state[0];
    end
    return v;
endfunction

`endif

//--- bench/mulacc_tb.sv
`timescale 1ns/1ps

module mulacc_tb
    import mulacc_pkg::*;
();

`include "mulacc_ref.svh"

    localparam int TIMEOUT    = 200;   // Cycles allowed for any single wait.
    localparam int NUM_RANDOM = 200;

    logic              clk;
    logic              reset;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [PROD_W-1:0] pwdata;
    logic [PROD_W-1:0] prdata;
    logic              pready;
    logic              pslverr;

    logic [PROD_W-1:0] got_q [$];
    logic [PROD_W-1:0] exp_q [$];
    string             what_q [$];

    logic [31:0]       lfsr_state = 32'hf650;
    logic [PROD_W-1:0] exp_acc;
    logic [PROD_W-1:0] rdata;
    logic [PROD_W-1:0] held;
    logic [MUL_W-1:0]  op_x;
    logic [MUL_W-1:0]  op_y;
    logic              err;
    int                checks = 0;
    int                fails = 0;
    int                tests_run = 0;
    int                tests_failed = 0;
    int                checks_at_start;
    int                fails_at_start;

    // Corner operands as {x, y}.
    logic [PROD_W-1:0] corner [6] = '{32'h8000_8000, 32'h0000_1234, 32'hffff_0001,
                                      32'h7fff_7fff, 32'h8000_7fff, 32'hffff_ffff};

    mulacc_top i_mulacc_top (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [PROD_W-1:0] expected_product(input logic [MUL_W-1:0] x,
                                                           input logic [MUL_W-1:0] y,
                                                           input logic mode);
        return mode ? ref_mul_approx(x, y) : ref_mul_exact(x, y);
    endfunction

    task automatic abort_run(input string why);
        $display("%0t: %s", $time, why);
        $display("RESULT: FAIL");
        $finish;
    endtask

    // Starts and ends on a falling edge with the bus idle.
    task automatic bus_xfer(input logic write, input logic [ADDR_W-1:0] addr,
                            input logic [PROD_W-1:0] wdata,
                            output logic [PROD_W-1:0] data, output logic slverr);
        int waited;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        waited  = 0;
        while (!pready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!pready) begin
            abort_run($sformatf("APB access to address %h never got pready", addr));
        end else begin
            data   = prdata;
            slverr = pslverr;
            @(negedge clk);              // Transfer completes on the rising edge before.
            psel    = 1'b0;
            penable = 1'b0;
        end
    endtask

    task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [PROD_W-1:0] data);
        logic [PROD_W-1:0] unused;
        logic              slverr;
        bus_xfer(1'b1, addr, data, unused, slverr);
    endtask

    task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [PROD_W-1:0] data);
        logic slverr;
        bus_xfer(1'b0, addr, '0, data, slverr);
    endtask

    task automatic expect_value(input logic [PROD_W-1:0] got, input logic [PROD_W-1:0] exp,
                                input string what);
        got_q.push_back(got);
        exp_q.push_back(exp);
        what_q.push_back(what);
    endtask

    task automatic clear_acc(input logic mode);
        write_reg(ADDR_CTRL, {30'b0, 1'b1, mode});
        exp_acc = '0;
    endtask

    task automatic issue_product(input logic [MUL_W-1:0] x, input logic [MUL_W-1:0] y,
                                 input logic mode);
        exp_acc = exp_acc + expected_product(x, y, mode);
        write_reg(ADDR_OPS, {x, y});
    endtask

    task automatic run_random(input logic mode, input int n);
        logic [MUL_W-1:0] x;
        logic [MUL_W-1:0] y;
        clear_acc(mode);
        for (int i = 0; i < n; i++) begin
            x = lfsr_operand(lfsr_state);
            y = lfsr_operand(lfsr_state);
            issue_product(x, y, mode);
        end
        read_reg(ADDR_ACC, rdata);
        expect_value(rdata, exp_acc, "random sum");
    endtask

    task automatic start_test;
        checks_at_start = checks;
        fails_at_start  = fails;
    endtask

    task automatic finish_test(input string name);
        int waited;
        waited = 0;
        while (got_q.size() != 0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (got_q.size() != 0) begin
            abort_run("compare process never drained its queue");
        end else begin
            tests_run++;
            if (fails != fails_at_start) begin
                tests_failed++;
            end
            $display("test %s: %0d checks, %0d failed", name, checks - checks_at_start,
                     fails - fails_at_start);
        end
    endtask

    task automatic apply_reset;
        reset = 1'b1;
        repeat (10) @(negedge clk);
        reset = 1'b0;
    endtask

    // Compare process.
    always @(posedge clk) begin : compare
        logic [PROD_W-1:0] got;
        logic [PROD_W-1:0] exp;
        string             what;
        while (got_q.size() > 0) begin
            got  = got_q.pop_front();
            exp  = exp_q.pop_front();
            what = what_q.pop_front();
            checks++;
            assert (got == exp) else begin
                $display("CHECK FAILED at %0t: %s read %h, expected %h", $time, what, got, exp);
                fails++;
            end
        end
    end

    initial begin
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        exp_acc = '0;
        apply_reset;

        for (int m = 0; m < 2; m++) begin
            start_test;
            for (int i = 0; i < 6; i++) begin
                clear_acc(m[0]);
                issue_product(corner[i][31:16], corner[i][15:0], m[0]);
                read_reg(ADDR_ACC, rdata);
                expect_value(rdata, exp_acc, "single product");
            end
            finish_test(m ? "approx_single" : "exact_single");
            start_test;
            run_random(m[0], NUM_RANDOM);
            finish_test(m ? "approx_accumulate" : "exact_accumulate");
        end

        start_test;
        clear_acc(1'b0);
        for (int i = 0; i < 40; i++) begin
            write_reg(ADDR_CTRL, {31'b0, i[0]});   // Mode only, no clear.
            op_x = lfsr_operand(lfsr_state);
            op_y = lfsr_operand(lfsr_state);
            issue_product(op_x, op_y, i[0]);
        end
        read_reg(ADDR_ACC, rdata);
        expect_value(rdata, exp_acc, "mixed mode sum");
        finish_test("mode_per_item");

        start_test;
        clear_acc(1'b0);
        issue_product(16'h1234, 16'hfedc, 1'b0);
        issue_product(16'h8001, 16'h0003, 1'b0);
        read_reg(ADDR_ACC, rdata);
        expect_value(rdata, exp_acc, "read right after issue");
        issue_product(16'h4321, 16'h00ff, 1'b0);
        clear_acc(1'b0);                          // Waits for the item in flight.
        read_reg(ADDR_ACC, rdata);
        expect_value(rdata, 32'h0, "ACC after clear");
        read_reg(ADDR_STATUS, rdata);
        expect_value(rdata, 32'h0, "STATUS when idle");
        finish_test("backpressure_clear");

        start_test;
        clear_acc(1'b0);
        issue_product(16'hc000, 16'h0123, 1'b0);
        read_reg(ADDR_ACC, held);
        expect_value(held, exp_acc, "ACC before bad access");
        bus_xfer(1'b1, 12'h010, 32'hdead_beef, rdata, err);
        expect_value({31'b0, err}, 32'h1, "pslverr on unmapped write");
        bus_xfer(1'b0, 12'h020, '0, rdata, err);
        expect_value({31'b0, err}, 32'h1, "pslverr on unmapped read");
        bus_xfer(1'b0, ADDR_ACC, '0, rdata, err);
        expect_value(rdata, exp_acc, "ACC after bad access");
        expect_value({31'b0, err}, 32'h0, "pslverr on ACC read");
        write_reg(ADDR_OPS, {16'h0101, 16'h0202});   // Left in flight across reset.
        psel    = 1'b1;                              // Unmapped setup, cut short by reset.
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 12'h020;
        @(negedge clk);
        psel    = 1'b0;
        apply_reset;
        for (int i = 0; i < 3; i++) begin
            expect_value({30'b0, pready, pslverr}, 32'h0, "pready and pslverr after reset");
            @(negedge clk);
        end
        read_reg(ADDR_ACC, rdata);
        expect_value(rdata, 32'h0, "ACC after reset");
        read_reg(ADDR_STATUS, rdata);
        expect_value(rdata, 32'h0, "STATUS after reset");
        finish_test("errors_reset");

        $display("tests: %0d run, %0d failed; checks: %0d run, %0d failed",
                 tests_run, tests_failed, checks, fails);
        if (fails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- hw/mulacc_top.sv
`timescale 1ns/1ps

module mulacc_top
    import mulacc_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [ADDR_W-1:0] paddr,
    input  logic [PROD_W-1:0] pwdata,
    output logic [PROD_W-1:0] prdata,
    output logic              pready,
    output logic              pslverr
);

    logic                       issue;
    logic                       approx;
    logic [MUL_W-1:0]           x;
    logic [MUL_W-1:0]           y;
    logic                       acc_clear;
    logic                       pp_valid;
    logic                       pp_approx;
    logic [MUL_W-1:0][PP_W-1:0] pp_rows;
    logic                       prod_valid;
    logic [PROD_W-1:0]          prod;
    logic [PROD_W-1:0]          acc;
    logic                       done;

    mulacc_apb_regs i_regs (
        .clk       (clk),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .busy      (prod_valid),   // Product about to enter the accumulator.
        .done      (done),
        .acc       (acc),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .issue     (issue),
        .approx    (approx),
        .x         (x),
        .y         (y),
        .acc_clear (acc_clear)
    );

    bw_pp_gen i_pp_gen (
        .clk       (clk),
        .reset     (reset),
        .issue     (issue),
        .approx    (approx),
        .x         (x),
        .y         (y),
        .pp_valid  (pp_valid),
        .pp_approx (pp_approx),
        .pp_rows   (pp_rows)
    );

    bw_reduce i_reduce (
        .clk        (clk),
        .reset      (reset),
        .pp_valid   (pp_valid),
        .pp_approx  (pp_approx),
        .pp_rows    (pp_rows),
        .prod_valid (prod_valid),
        .prod       (prod)
    );

    mac_accumulate i_acc (
        .clk        (clk),
        .reset      (reset),
        .prod_valid (prod_valid),
        .prod       (prod),
        .acc_clear  (acc_clear),
        .acc        (acc),
        .done       (done)
    );

endmodule

//--- hw/mac_accumulate.sv
`timescale 1ns/1ps

module mac_accumulate
    import mulacc_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              prod_valid,
    input  logic [PROD_W-1:0] prod,
    input  logic              acc_clear,
    output logic [PROD_W-1:0] acc,
    output logic              done
);

    logic [PROD_W-1:0] acc_next;

    // Plain modular add, no saturation.
    assign acc_next = acc + prod;

    always_ff @(posedge clk) begin
        if (reset) begin
            acc <= '0;
        end else if (acc_clear) begin
            acc <= '0;            // Only requested with the pipeline empty.
        end else if (prod_valid) begin
            acc <= acc_next;
        end
    end

    // Done is high while the new sum is already visible.
    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= prod_valid;
        end
    end

endmodule

//--- hw/bw_reduce.sv
`timescale 1ns/1ps

module bw_reduce
    import mulacc_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       pp_valid,
    input  logic                       pp_approx,
    input  logic [MUL_W-1:0][PP_W-1:0] pp_rows,
    output logic                       prod_valid,
    output logic [PROD_W-1:0]          prod
);

    logic [CORR_WORDS-1:0][CORR_W-1:0] corr;
    logic [PROD_W-1:0]                 sum;

    // Correction terms standing in for rows 0 to 5.
    always_comb begin
        corr = '0;

        corr[0][3]  = pp_rows[0][2] & pp_rows[1][1];
        corr[0][4]  = pp_rows[0][4] ^ pp_rows[1][3];
        corr[0][5]  = pp_rows[4][1] ^ pp_rows[5][0];
        corr[0][6]  = pp_rows[0][5] & pp_rows[1][4];
        corr[0][7]  = pp_rows[2][5] ^ pp_rows[3][4];
        corr[0][9]  = pp_rows[4][5] ^ pp_rows[5][4];
        corr[0][13] = pp_rows[2][10] & pp_rows[3][9];
        corr[0][14] = pp_rows[4][10] ^ pp_rows[5][9];
        corr[0][15] = pp_rows[2][13] ^ pp_rows[3][12];
        corr[0][16] = 1'b1;                           // Baugh-Wooley constant.
        corr[0][17] = pp_rows[1][15];
        corr[0][18] = pp_rows[2][15] & pp_rows[3][14];
        corr[0][19] = pp_rows[4][14] & pp_rows[5][13];
        corr[0][20] = pp_rows[4][15] & pp_rows[5][14];

        corr[1][3]  = pp_rows[0][3] ^ pp_rows[1][2];
        corr[1][4]  = pp_rows[2][2] ^ pp_rows[3][1];
        corr[1][7]  = pp_rows[4][2] & pp_rows[5][1];
        corr[1][16] = pp_rows[4][12] ^ pp_rows[5][11];
        corr[1][17] = pp_rows[2][15] ^ pp_rows[3][14];
        corr[1][18] = pp_rows[3][15];
        corr[1][19] = pp_rows[4][15] ^ pp_rows[5][14];
        corr[1][20] = pp_rows[5][15];

        corr[2][17] = pp_rows[4][12] & pp_rows[5][11];
        corr[2][18] = pp_rows[4][14] ^ pp_rows[5][13];

        corr[3][17] = pp_rows[4][13] ^ pp_rows[5][12];
    end

    // Shifted row sum, low rows swapped for the correction words in approx mode.
    always_comb begin
        sum = PROD_W'(1) << (PROD_W - 1);   // Constant one of the last row.
        if (pp_approx) begin
            for (int w = 0; w < CORR_WORDS; w++) begin
                sum = sum + PROD_W'(corr[w]);
            end
        end else begin
            sum = sum + (PROD_W'(1) << MUL_W);
        end
        for (int i = 0; i < MUL_W; i++) begin
            if (!pp_approx || i >= APPROX_ROWS) begin
                sum = sum + (PROD_W'(pp_rows[i]) << i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= pp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pp_valid) begin
            prod <= sum;
        end
    end

endmodule

//--- hw/bw_pp_gen.sv
`timescale 1ns/1ps

module bw_pp_gen
    import mulacc_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       issue,
    input  logic                       approx,
    input  logic [MUL_W-1:0]           x,
    input  logic [MUL_W-1:0]           y,
    output logic                       pp_valid,
    output logic                       pp_approx,
    output logic [MUL_W-1:0][PP_W-1:0] pp_rows
);

    logic [MUL_W-1:0][PP_W-1:0] rows;

    // Row i is y gated by x[i], with the Baugh-Wooley sign inversions.
    always_comb begin
        for (int i = 0; i < MUL_W; i++) begin
            rows[i] = y & {PP_W{x[i]}};
            if (i == MUL_W - 1) begin
                rows[i][PP_W-2:0] = ~rows[i][PP_W-2:0];   // Last row, low bits inverted.
            end else begin
                rows[i][PP_W-1] = ~rows[i][PP_W-1];       // Sign column inverted.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pp_valid <= 1'b0;
        end else begin
            pp_valid <= issue;
        end
    end

    // Mode travels with the item.
    always_ff @(posedge clk) begin
        if (issue) begin
            pp_approx <= approx;
            pp_rows   <= rows;
        end
    end

endmodule

//--- hw/mulacc_apb_regs.sv
`timescale 1ns/1ps

module mulacc_apb_regs
    import mulacc_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [ADDR_W-1:0] paddr,
    input  logic [PROD_W-1:0] pwdata,
    input  logic              busy,
    input  logic              done,
    input  logic [PROD_W-1:0] acc,
    output logic [PROD_W-1:0] prdata,
    output logic              pready,
    output logic              pslverr,
    output logic              issue,
    output logic              approx,
    output logic [MUL_W-1:0]  x,
    output logic [MUL_W-1:0]  y,
    output logic              acc_clear
);

    logic [CNT_W-1:0] count;
    logic             addr_ok;
    logic             acc_read;
    logic             clear_write;
    logic             pipe_empty;
    logic             xfer_done;
    logic             wr_done;

    assign addr_ok     = paddr inside {ADDR_CTRL, ADDR_OPS, ADDR_ACC, ADDR_STATUS};
    assign acc_read    = !pwrite && (paddr == ADDR_ACC);
    assign clear_write = pwrite && (paddr == ADDR_CTRL) && pwdata[CTRL_CLEAR];

    // An item whose done is showing has already landed in the accumulator.
    assign pipe_empty = !issue && !busy && (count == CNT_W'(done));

    assign xfer_done = psel && penable && pready;
    assign wr_done   = xfer_done && pwrite && addr_ok;
    assign acc_clear = wr_done && (paddr == ADDR_CTRL) && pwdata[CTRL_CLEAR];

    // Ready is raised from setup, or later if the access has to wait.
    always_ff @(posedge clk) begin
        if (reset) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end else if (xfer_done) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end else if (psel && !pready && (pipe_empty || !(acc_read || clear_write))) begin
            pready  <= 1'b1;
            pslverr <= !addr_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            approx <= 1'b0;
            issue  <= 1'b0;
        end else begin
            issue <= wr_done && (paddr == ADDR_OPS);   // One multiply per OPS write.
            if (wr_done && (paddr == ADDR_CTRL)) begin
                approx <= pwdata[CTRL_APPROX];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_done && (paddr == ADDR_OPS)) begin
            x <= pwdata[PROD_W-1:MUL_W];
            y <= pwdata[MUL_W-1:0];
        end
    end

    // Items between issue and the accumulator.
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({issue, done})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_comb begin
        case (paddr)
            ADDR_CTRL:   prdata = PROD_W'(approx);
            ADDR_OPS:    prdata = {x, y};
            ADDR_ACC:    prdata = acc;
            ADDR_STATUS: prdata = PROD_W'(count);
            default:     prdata = '0;
        endcase
    end

endmodule

//--- hw/mulacc_pkg.sv
package mulacc_pkg;

    // Datapath widths.
    localparam int MUL_W  = 16;   // Operand width.
    localparam int PROD_W = 32;   // Product, accumulator and APB data width.
    localparam int PP_W   = 16;   // One Baugh-Wooley partial-product row.

    // Approximate reduction.
    localparam int APPROX_ROWS = 6;    // Rows 0 to 5 are replaced by correction terms.
    localparam int CORR_W      = 21;   // Width of one correction word.
    localparam int CORR_WORDS  = 4;    // Number of correction words.

    // APB register map.
    localparam int              ADDR_W      = 12;
    localparam logic [ADDR_W-1:0] ADDR_CTRL   = 12'h000;
    localparam logic [ADDR_W-1:0] ADDR_OPS    = 12'h004;
    localparam logic [ADDR_W-1:0] ADDR_ACC    = 12'h008;
    localparam logic [ADDR_W-1:0] ADDR_STATUS = 12'h00C;

    // CTRL register bits.
    localparam int CTRL_APPROX = 0;
    localparam int CTRL_CLEAR  = 1;   // Self-clearing.

    // In-flight counter width, three items at most.
    localparam int CNT_W = 2;

endpackage
